//--- Makefile
# Verilator flow for the apple-1 memory bus
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_apple1_bus
RTL_TOP   ?= apple1_bus_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/apple1_bus_top.sv
/*
	apple1_bus_top
	apple-1 memory bus, arbiter + decoder with banks + cassette audio
*/
`timescale 1ns/1ps
`default_nettype none

`include "apple1_consts.svh"

module apple1_bus_top import apple1_pkg::*; (
	input  logic                      sys_clock,
	input  logic                      rst_n_i,

	// cpu port
	input  cpu_port_t                 cpu_i,
	input  logic                      cpu_strobe_i,
	output logic [`APPLE1_DATA_W-1:0] cpu_rdata_o,

	// download port
	input  dl_port_t                  dl_i,

	// cassette and audio
	input  logic                      tape_rx_i,
	input  logic                      mon_tape_in_i,
	output logic                      tape_out_o,
	output logic                      audio_o,

	output logic                      led_o // low while bytes arrive
);

	bus_req_t bus_req;    // registered access
	logic     aci_access; // pulse per cassette access
	logic     tape_in;    // latched, inverted tape level

	bus_arbiter u_arbiter (
		.sys_clock    (sys_clock),
		.rst_n_i      (rst_n_i),
		.cpu_i        (cpu_i),
		.cpu_strobe_i (cpu_strobe_i),
		.dl_i         (dl_i),
		.req_o        (bus_req),
		.led_o        (led_o)
	);

	// memories live inside
	bus_decoder u_decoder (
		.sys_clock    (sys_clock),
		.rst_n_i      (rst_n_i),
		.req_i        (bus_req),
		.tape_in_i    (tape_in),
		.aci_access_o (aci_access),
		.rdata_o      (cpu_rdata_o)
	);

	tape_audio u_tape (
		.sys_clock     (sys_clock),
		.rst_n_i       (rst_n_i),
		.tape_rx_i     (tape_rx_i),
		.mon_tape_in_i (mon_tape_in_i),
		.aci_access_i  (aci_access),
		.tape_in_o     (tape_in),
		.tape_out_o    (tape_out_o),
		.audio_o       (audio_o)
	);

endmodule

`default_nettype wire

//--- hw/apple1_consts.svh
/*
	apple-1 bus constants
	bus widths, memory map region bounds, memory depths, DAC width
*/
`ifndef APPLE1_CONSTS_SVH
`define APPLE1_CONSTS_SVH

// bus widths
`define APPLE1_ADDR_W      16 // cpu side address
`define APPLE1_DL_ADDR_W   25 // download address, low 16 bits used
`define APPLE1_DATA_W      8

// low system ram
`define APPLE1_RAM_BASE    16'h0000
`define APPLE1_RAM_LAST    16'h3FFF

// 0x4000..0xBFFF was external sdram, now reads as zero

// cassette interface, every access toggles tape out
`define APPLE1_ACI_BASE    16'hC000
`define APPLE1_ACI_LAST    16'hC1FF

// integer basic lives here
`define APPLE1_BASIC_BASE  16'hE000
`define APPLE1_BASIC_LAST  16'hEFFF

// wozmon, runs to the top of the map
`define APPLE1_ROM_BASE    16'hFF00

// memory depths in bytes
`define APPLE1_RAM_DEPTH   16384
`define APPLE1_BASIC_DEPTH 4096
`define APPLE1_ROM_DEPTH   256

// sigma-delta accumulator width
`define APPLE1_DAC_W       16

`endif

//--- hw/apple1_pkg.sv
/*
	apple-1 bus types
	cpu and download port structs, registered bus request, region enum
*/
`default_nettype none

`include "apple1_consts.svh"

package apple1_pkg;

	// cpu side access, qualified by a separate strobe
	typedef struct packed {
		logic [`APPLE1_ADDR_W-1:0] addr;
		logic [`APPLE1_DATA_W-1:0] wdata;
		logic                      we;   // write when set, else read
	} cpu_port_t;

	// download port from the io controller
	typedef struct packed {
		logic [`APPLE1_DL_ADDR_W-1:0] addr;
		logic [`APPLE1_DATA_W-1:0]    data;
		logic                         wr;     // one cycle per byte
		logic                         active; // held over whole download
	} dl_port_t;

	// single registered request seen by the decoder
	typedef struct packed {
		logic [`APPLE1_ADDR_W-1:0] addr;
		logic [`APPLE1_DATA_W-1:0] wdata;
		logic                      we;
		logic                      valid;   // one cycle per access
		logic                      from_dl; // only these may write rom
	} bus_req_t;

	// decoded memory map region
	typedef enum logic [2:0] {
		REG_RAM,
		REG_BASIC,
		REG_ROM,
		REG_ACI,
		REG_NONE
	} region_e;

endpackage

`default_nettype wire

//--- hw/bus_arbiter.sv
/*
	bus_arbiter
	picks download or cpu access, registers it as one bus request
	and drives the download activity led
*/
`timescale 1ns/1ps
`default_nettype none

`include "apple1_consts.svh"

module bus_arbiter import apple1_pkg::*; (
	input  logic      sys_clock,
	input  logic      rst_n_i,
	input  cpu_port_t cpu_i,
	input  logic      cpu_strobe_i,
	input  dl_port_t  dl_i,
	output bus_req_t  req_o,
	output logic      led_o
);

	logic dl_take;  // download byte this cycle
	logic cpu_take; // cpu access, locked out while downloading

	logic                      valid_q;
	logic                      led_q;
	logic [`APPLE1_ADDR_W-1:0] addr_q;
	logic [`APPLE1_DATA_W-1:0] wdata_q;
	logic                      we_q;
	logic                      from_dl_q;

	assign dl_take  = dl_i.active & dl_i.wr;
	assign cpu_take = cpu_strobe_i & ~dl_i.active; // cpu dropped during download

	// control part
	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
			led_q   <= 1'b1; // led off
		end else begin
			valid_q <= dl_take | cpu_take;
			led_q   <= ~dl_take; // active low blink per byte
		end
	end

	// payload, held while idle
	always_ff @(posedge sys_clock) begin
		if (dl_take) begin
			addr_q    <= dl_i.addr[`APPLE1_ADDR_W-1:0]; // upper bits unused
			wdata_q   <= dl_i.data;
			we_q      <= 1'b1;
			from_dl_q <= 1'b1;
		end else if (cpu_take) begin
			addr_q    <= cpu_i.addr;
			wdata_q   <= cpu_i.wdata;
			we_q      <= cpu_i.we;
			from_dl_q <= 1'b0;
		end
	end

	assign req_o = '{addr: addr_q, wdata: wdata_q, we: we_q, valid: valid_q,
		from_dl: from_dl_q};
	assign led_o = led_q;

endmodule

`default_nettype wire

//--- hw/bus_decoder.sv
/*
	bus_decoder
	region decode, bank write enables, aci access pulse
	and read data mux with hold between reads
*/
`timescale 1ns/1ps
`default_nettype none

`include "apple1_consts.svh"

module bus_decoder import apple1_pkg::*; (
	input  logic                      sys_clock,
	input  logic                      rst_n_i,
	input  bus_req_t                  req_i,
	input  logic                      tape_in_i,
	output logic                      aci_access_o,
	output logic [`APPLE1_DATA_W-1:0] rdata_o
);

	localparam int RAM_AW   = $clog2(`APPLE1_RAM_DEPTH);
	localparam int BASIC_AW = $clog2(`APPLE1_BASIC_DEPTH);
	localparam int ROM_AW   = $clog2(`APPLE1_ROM_DEPTH);

	region_e                   region;
	region_e                   region_q; // region of the read in flight
	logic                      wr, rd;
	logic                      ram_we, basic_we, rom_we;
	logic [`APPLE1_DATA_W-1:0] ram_rdata, basic_rdata, rom_rdata;
	logic [`APPLE1_DATA_W-1:0] rd_mux;
	logic [`APPLE1_DATA_W-1:0] hold_q;   // last completed read
	logic                      rd_q;
	logic                      tape_q;

	always_comb begin
		if (req_i.addr <= `APPLE1_RAM_LAST)
			region = REG_RAM;
		else if (req_i.addr >= `APPLE1_ACI_BASE && req_i.addr <= `APPLE1_ACI_LAST)
			region = REG_ACI;
		else if (req_i.addr >= `APPLE1_BASIC_BASE && req_i.addr <= `APPLE1_BASIC_LAST)
			region = REG_BASIC;
		else if (req_i.addr >= `APPLE1_ROM_BASE)
			region = REG_ROM;
		else
			region = REG_NONE; // old sdram window and holes
	end

	assign wr = req_i.valid & req_i.we;
	assign rd = req_i.valid & ~req_i.we;

	assign ram_we   = wr & (region == REG_RAM);
	assign basic_we = wr & (region == REG_BASIC);
	assign rom_we   = wr & req_i.from_dl & (region == REG_ROM); // cpu can't touch rom

	assign aci_access_o = req_i.valid & (region == REG_ACI); // reads and writes

	mem_bank #(.DEPTH(`APPLE1_RAM_DEPTH)) u_ram (
		.sys_clock (sys_clock),
		.addr_i    (req_i.addr[RAM_AW-1:0]),
		.wdata_i   (req_i.wdata),
		.we_i      (ram_we),
		.rdata_o   (ram_rdata)
	);

	mem_bank #(.DEPTH(`APPLE1_BASIC_DEPTH)) u_basic (
		.sys_clock (sys_clock),
		.addr_i    (req_i.addr[BASIC_AW-1:0]),
		.wdata_i   (req_i.wdata),
		.we_i      (basic_we),
		.rdata_o   (basic_rdata)
	);

	mem_bank #(.DEPTH(`APPLE1_ROM_DEPTH)) u_rom (
		.sys_clock (sys_clock),
		.addr_i    (req_i.addr[ROM_AW-1:0]),
		.wdata_i   (req_i.wdata),
		.we_i      (rom_we),
		.rdata_o   (rom_rdata)
	);

	// region and tape bit follow the bank read by one cycle
	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_q     <= 1'b0;
			region_q <= REG_NONE;
			hold_q   <= '0;
		end else begin
			rd_q   <= rd;
			hold_q <= rdata_o;
			if (rd)
				region_q <= region;
		end
	end

	always_ff @(posedge sys_clock) begin
		if (rd)
			tape_q <= tape_in_i;
	end

	always_comb begin
		case (region_q)
			REG_RAM:   rd_mux = ram_rdata;
			REG_BASIC: rd_mux = basic_rdata;
			REG_ROM:   rd_mux = rom_rdata;
			REG_ACI:   rd_mux = {tape_q, {(`APPLE1_DATA_W-1){1'b0}}}; // tape in on bit 7
			default:   rd_mux = '0;
		endcase
	end

	// new data right after a read, else keep the last one
	assign rdata_o = rd_q ? rd_mux : hold_q;

endmodule

`default_nettype wire

//--- hw/mem_bank.sv
/*
	mem_bank
	single port byte memory, synchronous write, registered read
*/
`timescale 1ns/1ps
`default_nettype none

`include "apple1_consts.svh"

module mem_bank #(
	parameter int DEPTH = 256 // bytes, power of two
) (
	input  logic                       sys_clock,
	input  logic [$clog2(DEPTH)-1:0]   addr_i,
	input  logic [`APPLE1_DATA_W-1:0]  wdata_i,
	input  logic                       we_i,
	output logic [`APPLE1_DATA_W-1:0]  rdata_o
);

	// contents undefined until written
	logic [`APPLE1_DATA_W-1:0] mem [DEPTH];
	logic [`APPLE1_DATA_W-1:0] rdata_q;

	// write port
	always_ff @(posedge sys_clock) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

	// read port
	// old data on a same cycle write, the bus never needs it
	always_ff @(posedge sys_clock) begin
		rdata_q <= mem[addr_i];
	end

	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- hw/tape_audio.sv
/*
	tape_audio
	cassette in latch, cassette out toggle, monitor select
	and first order sigma-delta dac for the 1-bit audio line
*/
`timescale 1ns/1ps
`default_nettype none

`include "apple1_consts.svh"

module tape_audio (
	input  logic sys_clock,
	input  logic rst_n_i,
	input  logic tape_rx_i,     // raw cassette audio in
	input  logic mon_tape_in_i, // 1 listens to tape in, 0 to tape out
	input  logic aci_access_i,
	output logic tape_in_o,
	output logic tape_out_o,
	output logic audio_o
);

	logic                     tape_in_q;
	logic                     tape_out_q;
	logic                     mon;
	logic [`APPLE1_DAC_W-1:0] dac_in;
	logic [`APPLE1_DAC_W-1:0] acc_q;
	logic [`APPLE1_DAC_W:0]   acc_sum; // one extra bit for the carry
	logic                     audio_q;

	// cassette side
	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tape_in_q  <= 1'b0;
			tape_out_q <= 1'b0;
		end else begin
			tape_in_q <= ~tape_rx_i; // input stage inverts
			if (aci_access_i)
				tape_out_q <= ~tape_out_q;
		end
	end

	assign mon    = mon_tape_in_i ? tape_in_q : tape_out_q;
	assign dac_in = {mon, {(`APPLE1_DAC_W-1){1'b0}}}; // half scale or zero

	// sigma-delta, carry out is the pulse density
	assign acc_sum = {1'b0, acc_q} + {1'b0, dac_in};

	always_ff @(posedge sys_clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_q   <= '0;
			audio_q <= 1'b0;
		end else begin
			acc_q   <= acc_sum[`APPLE1_DAC_W-1:0];
			audio_q <= acc_sum[`APPLE1_DAC_W]; // 0101.. for a high level
		end
	end

	assign tape_in_o  = tape_in_q;
	assign tape_out_o = tape_out_q;
	assign audio_o    = audio_q;

endmodule

`default_nettype wire

//--- project.f
+incdir+hw
hw/apple1_pkg.sv
hw/bus_arbiter.sv
hw/mem_bank.sv
hw/bus_decoder.sv
hw/tape_audio.sv
hw/apple1_bus_top.sv
test/tb_apple1_bus.sv

//--- test/tb_apple1_bus.sv
/*
	tb_apple1_bus
	table driven testbench for the apple-1 memory bus
	lfsr write data, reference memory, watchdog, audio density checks
*/
`timescale 1ns/1ps
`default_nettype none

`include "apple1_consts.svh"

module tb_apple1_bus import apple1_pkg::*; ();

	localparam logic [1:0] OP_IDLE   = 2'd0;
	localparam logic [1:0] OP_DL_WR  = 2'd1;
	localparam logic [1:0] OP_CPU_WR = 2'd2;
	localparam logic [1:0] OP_CPU_RD = 2'd3;
	localparam int RG_RAM   = 0;
	localparam int RG_BASIC = 1;
	localparam int RG_ROM   = 2;
	localparam int RG_ACI   = 3;
	localparam int RG_NONE  = 4;

	logic                      sys_clock;
	logic                      rst_n_i;
	cpu_port_t                 cpu_i;
	logic                      cpu_strobe_i;
	dl_port_t                  dl_i;
	logic                      tape_rx_i;
	logic                      mon_tape_in_i;
	logic [`APPLE1_DATA_W-1:0] cpu_rdata_o;
	logic                      tape_out_o;
	logic                      audio_o;
	logic                      led_o;

	// stimulus table with one entry per cycle
	string       t_name[$];
	logic [1:0]  t_op[$];
	logic [15:0] t_addr[$];
	logic [7:0]  t_data[$];
	logic [7:0]  t_exp[$];  // expected read data
	logic        t_act[$];  // download flag held
	logic        t_tape[$]; // tape_rx level
	logic        t_tout[$]; // tape_out after this access

	logic [7:0]  model [65536]; // reference memory
	logic [31:0] lfsr;
	logic        tape_level;
	logic        tout_model;
	logic        table_ready;
	logic [7:0]  last_rd; // last completed read
	int          errors;
	int          checks;
	int          ones;

	apple1_bus_top i_dut (
		.sys_clock     (sys_clock),
		.rst_n_i       (rst_n_i),
		.cpu_i         (cpu_i),
		.cpu_strobe_i  (cpu_strobe_i),
		.cpu_rdata_o   (cpu_rdata_o),
		.dl_i          (dl_i),
		.tape_rx_i     (tape_rx_i),
		.mon_tape_in_i (mon_tape_in_i),
		.tape_out_o    (tape_out_o),
		.audio_o       (audio_o),
		.led_o         (led_o)
	);

	initial begin
		sys_clock = 1'b0;
		forever #4 sys_clock = ~sys_clock; // 8 ns period
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			v    = {v[30:0], lfsr[31]}; // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// memory map as seen from the bus
	function automatic int map_region(input logic [15:0] a);
		if (a <= `APPLE1_RAM_LAST)
			return RG_RAM;
		if (a >= `APPLE1_ACI_BASE && a <= `APPLE1_ACI_LAST)
			return RG_ACI;
		if (a >= `APPLE1_BASIC_BASE && a <= `APPLE1_BASIC_LAST)
			return RG_BASIC;
		if (a >= `APPLE1_ROM_BASE)
			return RG_ROM;
		return RG_NONE;
	endfunction

	task automatic add_entry(input string name, input logic [1:0] op,
		input logic [15:0] addr, input logic [7:0] data, input logic act);
		int         rg;
		logic       taken;
		logic [7:0] exp_val;
		rg      = map_region(addr);
		taken   = (op == OP_DL_WR) ? act : (op != OP_IDLE && !act); // cpu dropped on act
		exp_val = 8'h00;
		if (op == OP_CPU_RD && rg == RG_ACI)
			exp_val = {~tape_level, 7'b0};
		else if (op == OP_CPU_RD && rg != RG_NONE)
			exp_val = model[addr];
		if (taken && rg == RG_ACI)
			tout_model = ~tout_model; // reads and writes both toggle
		if (taken && (op == OP_DL_WR || op == OP_CPU_WR) && rg != RG_ACI && rg != RG_NONE)
			if (op == OP_DL_WR || rg != RG_ROM)
				model[addr] = data; // rom only via download
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_exp.push_back(exp_val);
		t_act.push_back(act);
		t_tape.push_back(tape_level);
		t_tout.push_back(tout_model);
	endtask

	task automatic dl_write(input string name, input logic [15:0] addr);
		logic [31:0] r;
		rand_bits(8, r);
		add_entry(name, OP_DL_WR, addr, r[7:0], 1'b1);
	endtask

	task automatic cpu_write(input string name, input logic [15:0] addr, input logic act);
		logic [31:0] r;
		rand_bits(8, r);
		add_entry(name, OP_CPU_WR, addr, r[7:0], act);
	endtask

	task automatic cpu_read(input string name, input logic [15:0] addr);
		add_entry(name, OP_CPU_RD, addr, 8'h00, 1'b0);
	endtask

	task automatic idle(input string name, input logic act);
		add_entry(name, OP_IDLE, 16'h0000, 8'h00, act);
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [15:0] a;
		idle("dl_open", 1'b1); // download image into all three memories
		dl_write("dl_ram_lo", 16'h0000);
		dl_write("dl_ram_mid", 16'h1234);
		dl_write("dl_ram_hi", 16'h3FFF);
		dl_write("dl_basic_lo", 16'hE000);
		dl_write("dl_basic_mid", 16'hEABC);
		dl_write("dl_basic_hi", 16'hEFFF);
		dl_write("dl_rom_lo", 16'hFF00);
		dl_write("dl_rom_vec", 16'hFFFC);
		dl_write("dl_rom_hi", 16'hFFFF);
		idle("dl_close", 1'b0);
		cpu_read("rd_ram_lo", 16'h0000);
		cpu_read("rd_ram_mid", 16'h1234);
		cpu_read("rd_ram_hi", 16'h3FFF);
		cpu_read("rd_basic_lo", 16'hE000);
		cpu_read("rd_basic_mid", 16'hEABC);
		cpu_read("rd_basic_hi", 16'hEFFF);
		cpu_read("rd_rom_lo", 16'hFF00);
		cpu_read("rd_rom_vec", 16'hFFFC);
		cpu_read("rd_rom_hi", 16'hFFFF);
		cpu_write("wr_ram_a", 16'h0100, 1'b0); // write then read back to back
		cpu_read("rd_ram_a", 16'h0100);
		cpu_write("wr_ram_b", 16'h2000, 1'b0);
		cpu_write("wr_basic_a", 16'hE800, 1'b0);
		cpu_read("rd_ram_b", 16'h2000);
		cpu_read("rd_basic_a", 16'hE800);
		cpu_write("wr_ram_over", 16'h1234, 1'b0);
		cpu_read("rd_ram_over", 16'h1234);
		cpu_write("wr_rom_lo", 16'hFF00, 1'b0); // rom must keep the image
		cpu_write("wr_rom_vec", 16'hFFFC, 1'b0);
		cpu_read("rd_rom_lo_kept", 16'hFF00);
		cpu_read("rd_rom_vec_kept", 16'hFFFC);
		idle("dl_reopen", 1'b1);
		cpu_write("wr_ram_locked", 16'h0000, 1'b1);
		cpu_write("wr_basic_locked", 16'hEFFF, 1'b1);
		idle("dl_reclose", 1'b0);
		cpu_read("rd_ram_locked", 16'h0000);
		cpu_read("rd_basic_locked", 16'hEFFF);
		cpu_read("rd_sdram_lo", 16'h4000); // old sdram window and holes
		cpu_read("rd_sdram_hi", 16'hBFFF);
		cpu_read("rd_hole_d000", 16'hD000);
		cpu_read("rd_hole_f000", 16'hF000);
		tape_level = 1'b0;
		idle("tape_low_0", 1'b0);
		idle("tape_low_1", 1'b0);
		cpu_read("rd_aci_low", 16'hC000);
		cpu_write("wr_aci", 16'hC100, 1'b0);
		cpu_read("rd_aci_top_low", 16'hC1FF);
		tape_level = 1'b1;
		idle("tape_high_0", 1'b0);
		idle("tape_high_1", 1'b0);
		cpu_read("rd_aci_high", 16'hC010);
		cpu_read("rd_aci_high_b", 16'hC0FF);
		for (int i = 0; i < 6; i++) begin
			rand_bits(14, r);
			a = {2'b00, r[13:0]}; // somewhere in low ram
			cpu_write($sformatf("wr_rand_%0d", i), a, 1'b0);
			cpu_read($sformatf("rd_rand_%0d", i), a);
		end
	endtask

	task automatic drive_entry(input int k);
		cpu_strobe_i = (t_op[k] == OP_CPU_WR || t_op[k] == OP_CPU_RD);
		cpu_i.addr   = t_addr[k];
		cpu_i.wdata  = t_data[k];
		cpu_i.we     = (t_op[k] == OP_CPU_WR);
		dl_i.addr    = {9'h15A, t_addr[k]}; // junk above bit 15 gets dropped
		dl_i.data    = t_data[k];
		dl_i.wr      = (t_op[k] == OP_DL_WR);
		dl_i.active  = t_act[k];
		tape_rx_i    = t_tape[k];
	endtask

	task automatic drive_idle();
		cpu_strobe_i = 1'b0;
		dl_i.wr      = 1'b0;
		dl_i.active  = 1'b0;
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] exp_val,
		input logic [7:0] act_val);
		errors++;
		$display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
	endtask

	task automatic count_audio(output int n);
		n = 0;
		repeat (64) begin
			@(posedge sys_clock);
			#4;
			n = n + int'(audio_o);
		end
	endtask

	// watchdog
	initial begin
		int limit_ns;
		wait (table_ready === 1'b1);
		limit_ns = (t_name.size() + 200) * 8 * 2;
		#(limit_ns);
		$display("timeout: simulation still running after %0d ns", limit_ns);
		$display("Errors found");
		$finish;
	end

	initial begin
		rst_n_i       = 1'b0;
		cpu_i         = '0;
		cpu_strobe_i  = 1'b0;
		dl_i          = '0;
		tape_rx_i     = 1'b0;
		mon_tape_in_i = 1'b0; // listen to tape out during the table
		lfsr          = 32'h57c2ca15;
		tape_level    = 1'b0;
		tout_model    = 1'b0;
		last_rd       = 8'h00;
		errors        = 0;
		checks        = 0;
		build_table();
		table_ready = 1'b1;
		repeat (8) @(posedge sys_clock);
		#1;
		checks += 4;
		if (led_o !== 1'b1)
			report_mismatch("reset_led", 8'h01, {7'b0, led_o});
		if (tape_out_o !== 1'b0)
			report_mismatch("reset_tape_out", 8'h00, {7'b0, tape_out_o});
		if (audio_o !== 1'b0)
			report_mismatch("reset_audio", 8'h00, {7'b0, audio_o});
		if (cpu_rdata_o !== 8'h00)
			report_mismatch("reset_rdata", 8'h00, cpu_rdata_o);
		rst_n_i = 1'b1;

		// read data of entry k is valid between edges k+2 and k+3
		for (int i = 0; i < t_name.size() + 2; i++) begin
			@(posedge sys_clock);
			#1;
			if (i < t_name.size())
				drive_entry(i);
			else
				drive_idle();
			#3;
			if (i >= 2) begin
				if (t_op[i-2] == OP_CPU_RD && !t_act[i-2])
					last_rd = t_exp[i-2]; // otherwise the last read holds
				checks++;
				if (cpu_rdata_o !== last_rd)
					report_mismatch(t_name[i-2], last_rd, cpu_rdata_o);
				checks++;
				if (tape_out_o !== t_tout[i-2])
					report_mismatch({t_name[i-2], "_tape_out"}, {7'b0, t_tout[i-2]},
						{7'b0, tape_out_o});
			end
			if (i >= 1) begin
				checks++;
				if (led_o !== !(t_op[i-1] == OP_DL_WR && t_act[i-1]))
					report_mismatch({t_name[i-1], "_led"},
						{7'b0, !(t_op[i-1] == OP_DL_WR && t_act[i-1])}, {7'b0, led_o});
			end
		end

		// audio density with the monitor still on tape out
		repeat (4) @(posedge sys_clock);
		count_audio(ones);
		checks++;
		if (tout_model && (ones < 31 || ones > 33))
			report_mismatch("audio_tape_out", 8'd32, 8'(ones));
		else if (!tout_model && ones != 0)
			report_mismatch("audio_tape_out", 8'd0, 8'(ones));

		// audio density with the monitor on tape in
		@(posedge sys_clock);
		#1;
		mon_tape_in_i = 1'b1;
		tape_rx_i     = 1'b1; // inverted so the level is low
		repeat (4) @(posedge sys_clock);
		count_audio(ones);
		checks++;
		if (ones != 0)
			report_mismatch("audio_low", 8'd0, 8'(ones));
		@(posedge sys_clock);
		#1;
		tape_rx_i = 1'b0; // level high
		repeat (4) @(posedge sys_clock);
		count_audio(ones);
		checks++;
		if (ones < 31 || ones > 33)
			report_mismatch("audio_high", 8'd32, 8'(ones));

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire
